//--- project.f
logic/priv_pkg.sv
logic/csr_rfile.sv
logic/mtimer.sv
logic/trap_cause_enc.sv
logic/trap_ctrl.sv
logic/priv_unit.sv
verification/priv_unit_chk.sv
verification/priv_unit_tb.sv

//--- verification/priv_unit_tb.sv
// --------------------------------------------------------------------------
// Testbench for the machine-mode privilege unit. Runs CSR accesses,
// exceptions, mret, software and timer interrupts, and checks reads and
// redirects against a CSR model kept here in the testbench.
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module priv_unit_tb import priv_pkg::*; ();

  localparam word_t TRAP_VEC   = 32'h0000_0100; // DUT default
  localparam word_t EXP_MCPUID = 32'h0000_0100; // RV32 base, letter I
  localparam int    TIMEOUT    = 100;

  logic        CLK;
  logic        nRST;
  logic [11:0] csr_addr;
  logic        csr_swap;
  logic        csr_set;
  logic        csr_clr;
  word_t       csr_wdata;
  word_t       csr_rdata;
  logic        invalid_csr;
  logic        ex_valid;
  logic [4:0]  ex_cause;
  word_t       ex_badaddr;
  word_t       commit_pc;
  logic        mret_req;
  logic        sw_irq;
  logic        fromhost_wr;
  word_t       fromhost_data;
  logic        redirect;
  word_t       redirect_pc;
  word_t       tohost;

  // Reference CSR state
  logic  m_ie;
  logic  m_ie1;
  logic  m_msie;
  logic  m_mtie;
  logic  m_msip;
  logic  m_mtip;
  word_t m_mscratch;
  word_t m_mepc;
  word_t m_mcause;
  word_t m_mbadaddr;
  word_t m_tohost;
  word_t m_fromhost;
  word_t m_cmp;

  int          errors;
  int          checks;
  int          redir_cnt;
  logic        chk_rd;    // Compare csr_rdata this cycle
  logic        redir_exp;
  word_t       exp_pc;
  logic [31:0] rng;

  priv_unit u_dut (
    .CLK          (CLK),
    .nRST         (nRST),
    .csr_addr     (csr_addr),
    .csr_swap     (csr_swap),
    .csr_set      (csr_set),
    .csr_clr      (csr_clr),
    .csr_wdata    (csr_wdata),
    .csr_rdata    (csr_rdata),
    .invalid_csr  (invalid_csr),
    .ex_valid     (ex_valid),
    .ex_cause     (ex_cause),
    .ex_badaddr   (ex_badaddr),
    .commit_pc    (commit_pc),
    .mret_req     (mret_req),
    .sw_irq       (sw_irq),
    .fromhost_wr  (fromhost_wr),
    .fromhost_data(fromhost_data),
    .redirect     (redirect),
    .redirect_pc  (redirect_pc),
    .tohost       (tohost)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic known_addr(input logic [11:0] a);
    case (a)
      MCPUID, MIMPID, MHARTID, MSTATUS, MTVEC, MTDELEG, MIE, MTIMECMP,
      MSCRATCH, MEPC, MCAUSE, MBADADDR, MIP, MBASE, MBOUND, MIBASE,
      MIBOUND, MDBASE, MDBOUND, MTIME, MTIMEH, MTOHOST, MFROMHOST: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // Expected read value, only writable fields survive
  function automatic word_t ref_csr(input logic [11:0] a);
    word_t v;
    v = '0;
    case (a)
      MCPUID:    v = EXP_MCPUID;
      MTVEC:     v = TRAP_VEC;
      MSTATUS: begin
        v[0] = m_ie;
        v[3] = m_ie1;
      end
      MIE: begin
        v[3] = m_msie;
        v[7] = m_mtie;
      end
      MIP: begin
        v[3] = m_msip;
        v[7] = m_mtip;
      end
      MTIMECMP:  v = m_cmp;
      MSCRATCH:  v = m_mscratch;
      MEPC:      v = m_mepc;
      MCAUSE:    v = m_mcause;
      MBADADDR:  v = m_mbadaddr;
      MTOHOST:   v = m_tohost;
      MFROMHOST: v = m_fromhost;
      default:   v = '0; // Ids, delegation and protection read zero
    endcase
    return v;
  endfunction

  task automatic model_write(input csr_op_t op, input logic [11:0] a, input word_t d);
    word_t nv;
    case (op)
      CSR_SWAP: nv = d;
      CSR_SET:  nv = ref_csr(a) | d;
      default:  nv = ref_csr(a) & ~d;
    endcase
    case (a)
      MSTATUS: begin
        m_ie  = nv[0];
        m_ie1 = nv[3];
      end
      MIE: begin
        m_msie = nv[3];
        m_mtie = nv[7];
      end
      MSCRATCH: m_mscratch = nv;
      MEPC:     m_mepc     = {nv[31:2], 2'b00};
      MTOHOST:  m_tohost   = nv;
      MTIMECMP: begin
        m_cmp  = nv;
        m_mtip = 1'b0; // Compare write drops the pending bit
      end
      default: ;
    endcase
  endtask

  task automatic model_trap(input word_t cause, input logic is_exc, input word_t badaddr,
                            input word_t pc);
    m_mepc   = {pc[31:2], 2'b00};
    m_mcause = cause;
    if (is_exc) m_mbadaddr = badaddr;
    m_ie1 = m_ie;
    m_ie  = 1'b0;
  endtask

  always @(posedge CLK or negedge nRST) begin
    if (!nRST) m_msip <= 1'b0;
    else       m_msip <= sw_irq;
  end

  // Compare process, samples mid-cycle
  always @(negedge CLK) begin
    if (nRST) begin
      checks++;
      assert (invalid_csr == ((csr_swap || csr_set || csr_clr) && !known_addr(csr_addr)))
      else begin
        errors++;
        $display("mismatch invalid_csr at addr %h: got %h exp %h", csr_addr, invalid_csr,
                 (csr_swap || csr_set || csr_clr) && !known_addr(csr_addr));
      end
      assert (tohost == m_tohost) else begin
        errors++;
        $display("mismatch tohost: got %h exp %h", tohost, m_tohost);
      end
      if (chk_rd) begin
        assert (csr_rdata == ref_csr(csr_addr)) else begin
          errors++;
          $display("mismatch csr_rdata at addr %h: got %h exp %h", csr_addr, csr_rdata,
                   ref_csr(csr_addr));
        end
      end
      if (redirect) begin
        redir_cnt++;
        assert (redir_exp) else begin
          errors++;
          $display("unexpected redirect to %h", redirect_pc);
        end
        assert (redirect_pc == exp_pc) else begin
          errors++;
          $display("mismatch redirect_pc: got %h exp %h", redirect_pc, exp_pc);
        end
      end
    end
  end

  task automatic step();
    @(posedge CLK);
    #2;
  endtask

  task automatic csr_write(input csr_op_t op, input logic [11:0] a, input word_t d);
    csr_addr  = a;
    csr_wdata = d;
    csr_swap  = (op == CSR_SWAP);
    csr_set   = (op == CSR_SET);
    csr_clr   = (op == CSR_CLR);
    chk_rd    = known_addr(a) && a != MTIME && a != MTIMEH; // Old value
    @(posedge CLK);
    model_write(op, a, d);
    #2;
    csr_swap = 1'b0;
    csr_set  = 1'b0;
    csr_clr  = 1'b0;
    chk_rd   = 1'b0;
  endtask

  task automatic csr_read(input logic [11:0] a);
    csr_addr = a;
    chk_rd   = 1'b1;
    step();
    chk_rd   = 1'b0;
  endtask

  task automatic wait_redirect(input int start);
    int n;
    n = 0;
    while (redir_cnt == start && n < TIMEOUT) begin
      step();
      n++;
    end
    assert (redir_cnt != start) else begin
      errors++;
      $display("timeout after %0d cycles waiting for redirect", TIMEOUT);
    end
    redir_exp = 1'b0;
  endtask

  task automatic raise_exception(input logic [4:0] cause, input word_t badaddr,
                                 input word_t pc);
    int start;
    start      = redir_cnt;
    exp_pc     = TRAP_VEC;
    redir_exp  = 1'b1;
    ex_valid   = 1'b1;
    ex_cause   = cause;
    ex_badaddr = badaddr;
    commit_pc  = pc;
    @(posedge CLK);
    model_trap({27'd0, cause}, 1'b1, badaddr, pc);
    #2;
    ex_valid = 1'b0;
    wait_redirect(start);
  endtask

  task automatic do_mret();
    int start;
    start     = redir_cnt;
    exp_pc    = m_mepc;
    redir_exp = 1'b1;
    mret_req  = 1'b1;
    @(posedge CLK);
    m_ie  = m_ie1;
    m_ie1 = 1'b1;
    #2;
    mret_req = 1'b0;
    wait_redirect(start);
  endtask

  task automatic zero_csr_check(input logic [11:0] a);
    csr_write(CSR_SWAP, a, 32'hffff_ffff);
    csr_read(a);
  endtask

  initial begin
    int          i;
    int          start;
    logic [11:0] a;
    csr_op_t     op;
    word_t       t0;
    word_t       t1;
    nRST = 1'b0;
    csr_addr = '0;
    csr_swap = 1'b0;
    csr_set = 1'b0;
    csr_clr = 1'b0;
    csr_wdata = '0;
    ex_valid = 1'b0;
    ex_cause = '0;
    ex_badaddr = '0;
    commit_pc = '0;
    mret_req = 1'b0;
    sw_irq = 1'b0;
    fromhost_wr = 1'b0;
    fromhost_data = '0;
    {m_ie1, m_msie, m_mtie} = 3'b000;
    m_ie = 1'b1;
    m_mtip = 1'b1; // Compare of zero matches at the first edge
    {m_mscratch, m_mepc, m_mcause, m_mbadaddr} = '0;
    {m_tohost, m_fromhost, m_cmp} = '0;
    errors = 0;
    checks = 0;
    redir_cnt = 0;
    chk_rd = 1'b0;
    redir_exp = 1'b0;
    exp_pc = '0;
    rng = 32'hccf2ce75;
    repeat (3) @(posedge CLK);
    #2;
    nRST = 1'b1;
    step();
    csr_write(CSR_SWAP, MTIMECMP, 32'hffff_ff00); // Park the timer far away

    // Random read-modify-write on the writable CSRs
    for (i = 0; i < 40; i++) begin
      rng = xorshift32(rng);
      case (rng[1:0])
        2'd0:    a = MSCRATCH;
        2'd1:    a = MIE;
        2'd2:    a = MTOHOST;
        default: a = MSTATUS;
      endcase
      case (rng[5:4])
        2'd0:    op = CSR_SWAP;
        2'd1:    op = CSR_SET;
        default: op = CSR_CLR;
      endcase
      rng = xorshift32(rng);
      csr_write(op, a, rng);
      csr_read(a);
    end

    // Constants, zero space and host mailbox
    csr_read(MCPUID);
    csr_read(MTVEC);
    csr_read(MHARTID);
    zero_csr_check(MBASE);
    zero_csr_check(MBOUND);
    zero_csr_check(MIBASE);
    zero_csr_check(MIBOUND);
    zero_csr_check(MDBASE);
    zero_csr_check(MDBOUND);
    zero_csr_check(MIMPID);
    zero_csr_check(MTDELEG);
    zero_csr_check(MCAUSE);  // Read-only to the pipeline
    zero_csr_check(MTVEC);
    csr_addr = 12'h7c0;      // Unlisted, no strobe
    step();
    csr_write(CSR_SET, 12'h7c0, 32'h1);
    rng = xorshift32(rng);
    fromhost_data = rng;
    fromhost_wr = 1'b1;
    @(posedge CLK);
    m_fromhost = fromhost_data;
    #2;
    fromhost_wr = 1'b0;
    csr_read(MFROMHOST);

    // Exception then mret
    csr_write(CSR_SWAP, MSTATUS, 32'h1);
    csr_write(CSR_SWAP, MIE, 32'h0);
    rng = xorshift32(rng);
    t0 = rng;
    rng = xorshift32(rng);
    raise_exception(5'd5, t0, rng | 32'h3);
    csr_read(MEPC);
    csr_read(MCAUSE);
    csr_read(MBADADDR);
    csr_read(MSTATUS);
    do_mret();
    csr_read(MSTATUS);

    // Software interrupt, masked first by IE
    csr_write(CSR_CLR, MSTATUS, 32'h1);
    csr_write(CSR_SET, MIE, 32'h8);
    sw_irq = 1'b1;
    repeat (5) step();
    csr_read(MIP);
    start = redir_cnt;
    exp_pc = TRAP_VEC;
    redir_exp = 1'b1;
    commit_pc = 32'h0000_1236;
    csr_write(CSR_SET, MSTATUS, 32'h1);
    @(posedge CLK);
    model_trap(32'h8000_0003, 1'b0, '0, commit_pc);
    #2;
    wait_redirect(start);
    csr_read(MCAUSE);
    csr_read(MEPC);
    csr_read(MSTATUS);
    csr_write(CSR_SET, MSTATUS, 32'h1); // MSI still pending, exception must win
    raise_exception(5'd2, 32'h0bad_0004, 32'h0000_2000);
    csr_read(MCAUSE);
    csr_read(MBADADDR);
    sw_irq = 1'b0;
    csr_write(CSR_CLR, MIE, 32'h8);

    // Timer count, interrupt and pending clear
    csr_addr = MTIME;
    #1 t0 = csr_rdata;
    repeat (7) step();
    #1 t1 = csr_rdata;
    checks++;
    assert (t1 - t0 == 32'd7) else begin
      errors++;
      $display("mismatch mtime delta: got %h exp %h", t1 - t0, 32'd7);
    end
    step();
    csr_write(CSR_SET, MIE, 32'h80);
    csr_write(CSR_SET, MSTATUS, 32'h1);
    csr_addr = MTIME;
    #1 t0 = csr_rdata;
    step();
    commit_pc = 32'h0000_4000;
    ex_badaddr = 32'hfeed_0008; // Interrupt must leave mbadaddr alone
    start = redir_cnt;
    exp_pc = TRAP_VEC;
    redir_exp = 1'b1;
    csr_write(CSR_SWAP, MTIMECMP, t0 + 32'd20);
    wait_redirect(start);
    model_trap(32'h8000_0007, 1'b0, '0, commit_pc);
    m_mtip = 1'b1;
    csr_read(MCAUSE);
    csr_read(MEPC);
    csr_read(MBADADDR);
    csr_read(MIP);
    csr_read(MSTATUS);
    csr_write(CSR_SWAP, MTIMECMP, 32'hffff_ff00);
    csr_read(MIP);

    // Return with IE1 clear keeps IE low
    csr_write(CSR_SWAP, MSTATUS, 32'h0);
    do_mret();
    csr_read(MSTATUS);

    step();
    errors += u_dut.u_trap_ctrl.u_priv_unit_chk.fail_cnt;
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- verification/priv_unit_chk.sv
// --------------------------------------------------------------------------
// Protocol assertions for the trap FSM, bound into every trap_ctrl
// instance. Covers redirect length, trap target and commit timing.
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module priv_unit_chk import priv_pkg::*; #(
  parameter word_t TRAP_VECTOR = 32'h0000_0100
) (
  input  logic        CLK,
  input  logic        nRST,
  input  logic        trap_commit,
  input  logic        ret_commit,
  input  logic        redirect,
  input  word_t       redirect_pc,
  input  trap_state_t state
);

  int fail_cnt = 0; // Assertion failures so far

  a_redirect_pulse: assert property (@(posedge CLK) disable iff (!nRST)
    redirect |=> !redirect)
    else begin
      fail_cnt++;
      $error("redirect held high for more than one cycle");
    end

  a_trap_target: assert property (@(posedge CLK) disable iff (!nRST)
    trap_commit |=> (redirect && redirect_pc == TRAP_VECTOR))
    else begin
      fail_cnt++;
      $error("trap commit not followed by redirect to the trap vector");
    end

  // Busy cycle after a commit accepts nothing
  a_commit_idle: assert property (@(posedge CLK) disable iff (!nRST)
    (trap_commit || ret_commit) |=> (state != TS_IDLE && !trap_commit && !ret_commit))
    else begin
      fail_cnt++;
      $error("commit seen outside the idle state");
    end

  a_reset_quiet: assert property (@(posedge CLK) !nRST |-> !redirect)
    else begin
      fail_cnt++;
      $error("redirect high during reset");
    end

endmodule

bind trap_ctrl priv_unit_chk #(.TRAP_VECTOR(TRAP_VECTOR)) u_priv_unit_chk (
  .CLK        (CLK),
  .nRST       (nRST),
  .trap_commit(trap_commit),
  .ret_commit (ret_commit),
  .redirect   (redirect),
  .redirect_pc(redirect_pc),
  .state      (state)
);

//--- logic/priv_unit.sv
// --------------------------------------------------------------------------
// Top of the machine-mode privilege unit. Wires the CSR file, timer,
// cause encoder and trap FSM together and sets their parameters.
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module priv_unit import priv_pkg::*; #(
  parameter word_t TRAP_VECTOR = 32'h0000_0100,
  parameter word_t HART_ID     = 32'h0000_0000
) (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic [CSR_ADDR_W-1:0] csr_addr,
  input  logic                  csr_swap,
  input  logic                  csr_set,
  input  logic                  csr_clr,
  input  word_t                 csr_wdata,
  output word_t                 csr_rdata,
  output logic                  invalid_csr,
  input  logic                  ex_valid,
  input  logic [CAUSE_W-1:0]    ex_cause,
  input  word_t                 ex_badaddr,
  input  word_t                 commit_pc,
  input  logic                  mret_req,
  input  logic                  sw_irq,
  input  logic                  fromhost_wr,
  input  word_t                 fromhost_data,
  output logic                  redirect,
  output word_t                 redirect_pc,
  output word_t                 tohost
);

  logic  mstatus_ie;
  logic  msie;
  logic  mtie;
  logic  msip;
  logic  mtip;
  word_t mepc;
  logic  trap_req;
  word_t trap_cause;
  logic  trap_commit;
  logic  ret_commit;
  logic  time_wr_lo;
  logic  time_wr_hi;
  logic  cmp_wr;
  word_t time_wdata;
  word_t mtime_lo;
  word_t mtime_hi;
  word_t mtimecmp;

  csr_rfile #(
    .TRAP_VECTOR(TRAP_VECTOR),
    .HART_ID    (HART_ID)
  ) u_csr_rfile (
    .CLK          (CLK),
    .nRST         (nRST),
    .csr_addr     (csr_addr),
    .csr_swap     (csr_swap),
    .csr_set      (csr_set),
    .csr_clr      (csr_clr),
    .csr_wdata    (csr_wdata),
    .csr_rdata    (csr_rdata),
    .invalid_csr  (invalid_csr),
    .commit_pc    (commit_pc),
    .ex_badaddr   (ex_badaddr),
    .trap_cause   (trap_cause),
    .ex_valid     (ex_valid),
    .sw_irq       (sw_irq),
    .trap_commit  (trap_commit),
    .ret_commit   (ret_commit),
    .mstatus_ie   (mstatus_ie),
    .msie         (msie),
    .mtie         (mtie),
    .msip         (msip),
    .mepc         (mepc),
    .fromhost_wr  (fromhost_wr),
    .fromhost_data(fromhost_data),
    .tohost       (tohost),
    .mtime_lo     (mtime_lo),
    .mtime_hi     (mtime_hi),
    .mtimecmp     (mtimecmp),
    .mtip         (mtip),
    .time_wr_lo   (time_wr_lo),
    .time_wr_hi   (time_wr_hi),
    .cmp_wr       (cmp_wr),
    .time_wdata   (time_wdata)
  );

  mtimer u_mtimer (
    .CLK       (CLK),
    .nRST      (nRST),
    .time_wr_lo(time_wr_lo),
    .time_wr_hi(time_wr_hi),
    .cmp_wr    (cmp_wr),
    .time_wdata(time_wdata),
    .mtime_lo  (mtime_lo),
    .mtime_hi  (mtime_hi),
    .mtimecmp  (mtimecmp),
    .mtip      (mtip)
  );

  trap_cause_enc u_trap_cause_enc (
    .ex_valid  (ex_valid),
    .ex_cause  (ex_cause),
    .mstatus_ie(mstatus_ie),
    .msie      (msie),
    .mtie      (mtie),
    .msip      (msip),
    .mtip      (mtip),
    .trap_req  (trap_req),
    .trap_cause(trap_cause)
  );

  trap_ctrl #(
    .TRAP_VECTOR(TRAP_VECTOR)
  ) u_trap_ctrl (
    .CLK        (CLK),
    .nRST       (nRST),
    .trap_req   (trap_req),
    .mret_req   (mret_req),
    .mepc       (mepc),
    .trap_commit(trap_commit),
    .ret_commit (ret_commit),
    .redirect   (redirect),
    .redirect_pc(redirect_pc)
  );

endmodule

//--- logic/trap_ctrl.sv
// --------------------------------------------------------------------------
// Trap and return sequencing. A request in idle commits at that edge and
// the following cycle pulses redirect with the registered target. New
// requests are ignored until the FSM is back in idle.
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module trap_ctrl import priv_pkg::*; #(
  parameter word_t TRAP_VECTOR = 32'h0000_0100
) (
  input  logic  CLK,
  input  logic  nRST,
  input  logic  trap_req,
  input  logic  mret_req,
  input  word_t mepc,
  output logic  trap_commit,
  output logic  ret_commit,
  output logic  redirect,
  output word_t redirect_pc
);

  trap_state_t state;
  trap_state_t state_next;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      state <= TS_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // Trap beats mret when both arrive together
  always_comb begin
    state_next  = state;
    trap_commit = 1'b0;
    ret_commit  = 1'b0;
    case (state)
      TS_IDLE: begin
        if (trap_req) begin
          trap_commit = 1'b1;
          state_next  = TS_TRAP;
        end else if (mret_req) begin
          ret_commit = 1'b1;
          state_next = TS_RET;
        end
      end
      TS_TRAP: state_next = TS_IDLE;
      TS_RET:  state_next = TS_IDLE;
      default: state_next = TS_IDLE;
    endcase
  end

  // Target captured at commit, mepc is still the old value here
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      redirect_pc <= '0;
    end else if (trap_commit) begin
      redirect_pc <= TRAP_VECTOR;
    end else if (ret_commit) begin
      redirect_pc <= mepc;
    end
  end

  assign redirect = (state == TS_TRAP) || (state == TS_RET); // One cycle only

endmodule

//--- logic/trap_cause_enc.sv
// --------------------------------------------------------------------------
// Picks the winning trap source and forms the mcause value.
// Exception first, then software interrupt, then timer interrupt.
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module trap_cause_enc import priv_pkg::*; (
  input  logic               ex_valid,
  input  logic [CAUSE_W-1:0] ex_cause,
  input  logic               mstatus_ie,
  input  logic               msie,
  input  logic               mtie,
  input  logic               msip,
  input  logic               mtip,
  output logic               trap_req,
  output word_t              trap_cause
);

  logic msi_take;
  logic mti_take;

  // Interrupt needs global and per-source enable
  assign msi_take = mstatus_ie && msie && msip;
  assign mti_take = mstatus_ie && mtie && mtip;

  assign trap_req = ex_valid || msi_take || mti_take;

  always_comb begin
    trap_cause = '0;
    if (ex_valid) begin
      trap_cause[CAUSE_W-1:0] = ex_cause; // Synchronous, no interrupt bit
    end else if (msi_take) begin
      trap_cause[CAUSE_W-1:0]   = CAUSE_MSI;
      trap_cause[CAUSE_INT_BIT] = 1'b1;
    end else if (mti_take) begin
      trap_cause[CAUSE_W-1:0]   = CAUSE_MTI;
      trap_cause[CAUSE_INT_BIT] = 1'b1;
    end
  end

endmodule

//--- logic/mtimer.sv
// --------------------------------------------------------------------------
// Machine timer: free-running 64-bit count, compare register and a sticky
// pending flag. Writes arrive as strobes from the CSR file.
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module mtimer import priv_pkg::*; (
  input  logic  CLK,
  input  logic  nRST,
  input  logic  time_wr_lo,
  input  logic  time_wr_hi,
  input  logic  cmp_wr,
  input  word_t time_wdata,
  output word_t mtime_lo,
  output word_t mtime_hi,
  output word_t mtimecmp,
  output logic  mtip
);

  logic [63:0] count;

  assign mtime_lo = count[31:0];
  assign mtime_hi = count[63:32];

  // A half-word write replaces that half and holds the count this edge
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      count <= '0;
    end else if (time_wr_lo) begin
      count <= {count[63:32], time_wdata};
    end else if (time_wr_hi) begin
      count <= {time_wdata, count[31:0]};
    end else begin
      count <= count + 64'd1;
    end
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      mtimecmp <= '0;
    end else if (cmp_wr) begin
      mtimecmp <= time_wdata;
    end
  end

  // Sticky until the compare value is rewritten
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      mtip <= 1'b0;
    end else if (cmp_wr) begin
      mtip <= 1'b0;
    end else if (mtime_lo == mtimecmp) begin
      mtip <= 1'b1;
    end
  end

endmodule

//--- logic/csr_rfile.sv
// --------------------------------------------------------------------------
// Machine CSR file. Serves combinational reads and read-modify-write
// accesses from the pipeline, applies trap and return commits from the
// trap controller, and forwards timer writes to the timer block.
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module csr_rfile import priv_pkg::*; #(
  parameter word_t TRAP_VECTOR = 32'h0000_0100,
  parameter word_t HART_ID     = 32'h0000_0000
) (
  input  logic                  CLK,
  input  logic                  nRST,
  // Pipeline access
  input  logic [CSR_ADDR_W-1:0] csr_addr,
  input  logic                  csr_swap,
  input  logic                  csr_set,
  input  logic                  csr_clr,
  input  word_t                 csr_wdata,
  output word_t                 csr_rdata,
  output logic                  invalid_csr,
  // Trap side
  input  word_t                 commit_pc,
  input  word_t                 ex_badaddr,
  input  word_t                 trap_cause,
  input  logic                  ex_valid,
  input  logic                  sw_irq,
  input  logic                  trap_commit,
  input  logic                  ret_commit,
  output logic                  mstatus_ie,
  output logic                  msie,
  output logic                  mtie,
  output logic                  msip,
  output word_t                 mepc,
  // Host mailbox
  input  logic                  fromhost_wr,
  input  word_t                 fromhost_data,
  output word_t                 tohost,
  // Timer
  input  word_t                 mtime_lo,
  input  word_t                 mtime_hi,
  input  word_t                 mtimecmp,
  input  logic                  mtip,
  output logic                  time_wr_lo,
  output logic                  time_wr_hi,
  output logic                  cmp_wr,
  output word_t                 time_wdata
);

  csr_addr_t addr;
  csr_op_t   op;
  logic      valid_addr;
  logic      wr_en;
  word_t     wval;
  logic      mstatus_ie1;
  word_t     mscratch;
  word_t     mcause;
  word_t     mbadaddr;
  word_t     mfromhost;

  assign addr = csr_addr_t'(csr_addr);

  // Strobes are one-hot by contract
  always_comb begin
    if (csr_swap)     op = CSR_SWAP;
    else if (csr_set) op = CSR_SET;
    else if (csr_clr) op = CSR_CLR;
    else              op = CSR_NONE;
  end

  always_comb begin
    csr_rdata  = '0;
    valid_addr = 1'b1;
    case (addr)
      MCPUID:    csr_rdata = MCPUID_RV32I;
      MIMPID:    csr_rdata = '0;
      MHARTID:   csr_rdata = HART_ID;
      MSTATUS: begin
        csr_rdata[MSTATUS_IE]  = mstatus_ie;
        csr_rdata[MSTATUS_IE1] = mstatus_ie1;
      end
      MTVEC:     csr_rdata = TRAP_VECTOR;
      MTDELEG:   csr_rdata = '0;
      MIE: begin
        csr_rdata[MIP_MSIP] = msie;
        csr_rdata[MIP_MTIP] = mtie;
      end
      MSCRATCH:  csr_rdata = mscratch;
      MEPC:      csr_rdata = mepc;
      MCAUSE:    csr_rdata = mcause;
      MBADADDR:  csr_rdata = mbadaddr;
      MIP: begin
        csr_rdata[MIP_MSIP] = msip;
        csr_rdata[MIP_MTIP] = mtip;
      end
      // No protection or translation, read as zero
      MBASE, MBOUND, MIBASE, MIBOUND, MDBASE, MDBOUND: csr_rdata = '0;
      MTIMECMP:  csr_rdata = mtimecmp;
      MTIME:     csr_rdata = mtime_lo;
      MTIMEH:    csr_rdata = mtime_hi;
      MTOHOST:   csr_rdata = tohost;
      MFROMHOST: csr_rdata = mfromhost;
      default:   valid_addr = 1'b0;
    endcase
  end

  assign invalid_csr = (op != CSR_NONE) && !valid_addr;
  assign wr_en       = (op != CSR_NONE) && valid_addr;

  // Read-modify-write value from the current read data
  always_comb begin
    case (op)
      CSR_SWAP: wval = csr_wdata;
      CSR_SET:  wval = csr_rdata | csr_wdata;
      CSR_CLR:  wval = csr_rdata & ~csr_wdata;
      default:  wval = csr_rdata;
    endcase
  end

  assign time_wr_lo = wr_en && (addr == MTIME);
  assign time_wr_hi = wr_en && (addr == MTIMEH);
  assign cmp_wr     = wr_en && (addr == MTIMECMP);
  assign time_wdata = wval;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      mstatus_ie  <= 1'b1;
      mstatus_ie1 <= 1'b0;
      msie        <= 1'b0;
      mtie        <= 1'b0;
      msip        <= 1'b0;
      mscratch    <= '0;
      mepc        <= '0;
      mcause      <= '0;
      mbadaddr    <= '0;
      tohost      <= '0;
      mfromhost   <= '0;
    end else begin
      msip <= sw_irq;
      if (fromhost_wr) mfromhost <= fromhost_data;
      // Commits take priority over pipeline writes
      if (trap_commit) begin
        mstatus_ie1 <= mstatus_ie;
        mstatus_ie  <= 1'b0;
        mepc        <= {commit_pc[31:2], 2'b00};
        mcause      <= trap_cause;
        if (ex_valid) mbadaddr <= ex_badaddr; // Exceptions only
      end else if (ret_commit) begin
        mstatus_ie  <= mstatus_ie1;
        mstatus_ie1 <= 1'b1;
      end else if (wr_en) begin
        case (addr)
          MSTATUS: begin
            mstatus_ie  <= wval[MSTATUS_IE];
            mstatus_ie1 <= wval[MSTATUS_IE1];
          end
          MEPC:    mepc <= {wval[31:2], 2'b00};
          default: ;
        endcase
      end
      if (wr_en) begin
        case (addr)
          MIE: begin
            msie <= wval[MIP_MSIP];
            mtie <= wval[MIP_MTIP];
          end
          MSCRATCH: mscratch <= wval;
          MTOHOST:  tohost   <= wval;
          default:  ;
        endcase
      end
    end
  end

endmodule

//--- logic/priv_pkg.sv
// --------------------------------------------------------------------------
// Shared types and constants for the machine-mode privilege unit.
// Import with priv_pkg::* in the module header of every block that needs
// CSR addresses, op codes, trap states or cause and bit positions.
// --------------------------------------------------------------------------
package priv_pkg;

  parameter int CSR_ADDR_W = 12;
  parameter int CAUSE_W    = 5;

  typedef logic [31:0] word_t;

  // Machine CSR map, older privileged spec layout
  typedef enum logic [CSR_ADDR_W-1:0] {
    MCPUID    = 12'hF00,
    MIMPID    = 12'hF01,
    MHARTID   = 12'hF10,
    MSTATUS   = 12'h300,
    MTVEC     = 12'h301,
    MTDELEG   = 12'h302,
    MIE       = 12'h304,
    MTIMECMP  = 12'h321,
    MSCRATCH  = 12'h340,
    MEPC      = 12'h341,
    MCAUSE    = 12'h342,
    MBADADDR  = 12'h343,
    MIP       = 12'h344,
    MBASE     = 12'h380,
    MBOUND    = 12'h381,
    MIBASE    = 12'h382,
    MIBOUND   = 12'h383,
    MDBASE    = 12'h384,
    MDBOUND   = 12'h385,
    MTIME     = 12'h701,
    MTIMEH    = 12'h741,
    MTOHOST   = 12'h780,
    MFROMHOST = 12'h781
  } csr_addr_t;

  typedef enum logic [1:0] {
    CSR_NONE = 2'd0,
    CSR_SWAP = 2'd1,
    CSR_SET  = 2'd2,
    CSR_CLR  = 2'd3
  } csr_op_t;

  typedef enum logic [1:0] {
    TS_IDLE = 2'd0,
    TS_TRAP = 2'd1, // Redirect to trap vector
    TS_RET  = 2'd2  // Redirect to mepc
  } trap_state_t;

  // Interrupt cause codes, bit 31 of mcause marks an interrupt
  parameter logic [CAUSE_W-1:0] CAUSE_MSI = 5'd3;
  parameter logic [CAUSE_W-1:0] CAUSE_MTI = 5'd7;
  parameter int CAUSE_INT_BIT = 31;

  // Two-level enable stack in mstatus
  parameter int MSTATUS_IE  = 0;
  parameter int MSTATUS_IE1 = 3;

  // Same positions in mie and mip
  parameter int MIP_MSIP = 3;
  parameter int MIP_MTIP = 7;

  // Base RV32 in [31:30], I extension is letter bit 8
  parameter word_t MCPUID_RV32I = 32'h0000_0100;

endpackage
